// File: mmu_pkg.sv
package mmu_pkg;

    // address types
    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [19:0] pfn_t;    // 4k pages
    typedef logic [2:0]  cache_attr_t;

    // cacheable noncoherent, the only attribute treated as cached
    localparam cache_attr_t ATTR_CACHED = 3'd3;

    // unmapped segments, by vaddr[31:29]
    localparam logic [2:0] SEG_KSEG0 = 3'd4;
    localparam logic [2:0] SEG_KSEG1 = 3'd5;

    // one lookup result, same cycle as the request
    typedef struct packed {
        logic        found;    // 0 means refill
        logic        valid;
        logic        dirty;    // write enable of the entry
        cache_attr_t attr;
        pfn_t        pfn;
    } tlb_resp_t;

    // translation result
    typedef struct packed {
        paddr_t paddr;
        logic   mapped;    // went through the tlb
        logic   cached;
    } xlate_t;

endpackage

// File: memop_pkg.sv
package memop_pkg;

    typedef enum logic [3:0] {
        OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR, OP_SC,
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR, OP_LL
    } mem_op_e;

    // Cause.ExcCode values
    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_MOD  = 5'd1,
        EXC_TLBL = 5'd2,
        EXC_TLBS = 5'd3,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5
    } exc_code_e;

    typedef enum logic [2:0] {
        LD_BYTE, LD_HALF, LD_WORD, LD_LEFT, LD_RIGHT
    } ld_size_e;

    typedef struct packed {
        logic           valid;
        mem_op_e        op;
        mmu_pkg::vaddr_t vaddr;
        logic [31:0]    wdata;    // rt value
    } mem_req_t;

    typedef struct packed {
        logic            exc;
        logic            refill;    // tlb miss, uses the refill vector
        exc_code_e       code;
        mmu_pkg::vaddr_t badvaddr;
    } exc_t;

    typedef struct packed {
        ld_size_e   size;
        logic       sign_ext;
        logic [1:0] offset;    // byte within the word
    } load_ctl_t;

    typedef struct packed {
        logic            cached_valid;
        logic            uncached_valid;
        logic            store;
        mmu_pkg::paddr_t paddr;
        logic [3:0]      wstrb;
        logic [31:0]     wdata;
        load_ctl_t       load_ctl;
    } mem_access_t;

    function automatic logic op_is_store(mem_op_e op);
        return op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR, OP_SC};
    endfunction

endpackage

// File: addr_translate.sv
`timescale 1ns/1ps

module addr_translate (
    input  mmu_pkg::vaddr_t     vaddr,
    input  mmu_pkg::tlb_resp_t  tlb,
    input  mmu_pkg::cache_attr_t k0_attr,
    output mmu_pkg::xlate_t     xlate
);

    logic [2:0]           seg;
    logic                 kseg0;
    logic                 kseg1;
    mmu_pkg::cache_attr_t attr;

    assign seg   = vaddr[31:29];
    assign kseg0 = (seg == mmu_pkg::SEG_KSEG0);
    assign kseg1 = (seg == mmu_pkg::SEG_KSEG1);

    always_comb begin
        xlate.mapped = !(kseg0 || kseg1);    // kuseg, kseg2, kseg3

        if (xlate.mapped)
            xlate.paddr = {tlb.pfn, vaddr[11:0]};
        else
            xlate.paddr = {3'b000, vaddr[28:0]};

        // attribute that applies to this segment
        if (kseg0)
            attr = k0_attr;
        else if (kseg1)
            attr = 3'd2;    // uncached
        else
            attr = tlb.attr;

        xlate.cached = (attr == mmu_pkg::ATTR_CACHED);
    end

endmodule

// File: exc_detect.sv
`timescale 1ns/1ps

module exc_detect (
    input  memop_pkg::mem_req_t req,
    input  mmu_pkg::tlb_resp_t  tlb,
    input  logic                mapped,
    output memop_pkg::exc_t     exc_now
);

    logic is_store;
    logic ades;
    logic adel;
    logic adr_err;
    logic tlb_miss;
    logic tlb_inv;
    logic tlb_mod;

    always_comb begin
        is_store = memop_pkg::op_is_store(req.op);
        ades = 1'b0;
        adel = 1'b0;
        case (req.op)
            memop_pkg::OP_SW, memop_pkg::OP_SC: ades = (req.vaddr[1:0] != 2'b00);
            memop_pkg::OP_SH:                   ades = req.vaddr[0];
            memop_pkg::OP_LW, memop_pkg::OP_LL: adel = (req.vaddr[1:0] != 2'b00);
            memop_pkg::OP_LH, memop_pkg::OP_LHU: adel = req.vaddr[0];
            default: ;    // byte and unaligned ops never fault on alignment
        endcase

        adr_err  = req.valid && (ades || adel);
        tlb_miss = req.valid && mapped && !tlb.found;
        tlb_inv  = req.valid && mapped && tlb.found && !tlb.valid;
        // store hitting a clean page
        tlb_mod  = req.valid && mapped && tlb.found && tlb.valid && !tlb.dirty && is_store;
    end

    // address error first, then tlb
    always_comb begin
        exc_now = '0;
        if (adr_err) begin
            exc_now.exc  = 1'b1;
            exc_now.code = ades ? memop_pkg::EXC_ADES : memop_pkg::EXC_ADEL;
        end else if (tlb_miss || tlb_inv) begin
            exc_now.exc    = 1'b1;
            exc_now.refill = tlb_miss;
            exc_now.code   = is_store ? memop_pkg::EXC_TLBS : memop_pkg::EXC_TLBL;
        end else if (tlb_mod) begin
            exc_now.exc  = 1'b1;
            exc_now.code = memop_pkg::EXC_MOD;
        end

        if (exc_now.exc)
            exc_now.badvaddr = req.vaddr;
    end

endmodule

// File: ll_sc_monitor.sv
`timescale 1ns/1ps

module ll_sc_monitor (
    input  logic                clk,
    input  logic                rst_n,
    input  memop_pkg::mem_req_t req,
    input  logic                exc_flag,
    output logic                sc_ok
);

    logic            link;
    mmu_pkg::vaddr_t link_addr;
    logic            ll_set;

    assign ll_set = req.valid && (req.op == memop_pkg::OP_LL) && !exc_flag;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            link <= 1'b0;
        else if (exc_flag)
            link <= 1'b0;    // any exception breaks the link
        else if (ll_set)
            link <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (ll_set)
            link_addr <= req.vaddr;
    end

    assign sc_ok = req.valid && (req.op == memop_pkg::OP_SC) && link
                   && (link_addr == req.vaddr);

    link_clear_after_exc: assert property (
        @(posedge clk) disable iff (!rst_n) exc_flag |=> !link
    ) else $error("link still set after exception");

endmodule

// File: lane_format.sv
`timescale 1ns/1ps

module lane_format (
    input  memop_pkg::mem_op_e  op,
    input  logic [1:0]          byte_off,
    input  logic [31:0]         rt,
    output logic [3:0]          wstrb,
    output logic [31:0]         wdata,
    output memop_pkg::load_ctl_t load_ctl
);

    logic [4:0] sh_up;    // 8*a
    logic [4:0] sh_dn;    // 8*(3-a)

    assign sh_up = {byte_off, 3'b000};
    assign sh_dn = {~byte_off, 3'b000};

    // store lanes, little endian
    always_comb begin
        wstrb = 4'b0000;
        wdata = rt;
        case (op)
            memop_pkg::OP_SB: begin
                wstrb = 4'b0001 << byte_off;
                wdata = {4{rt[7:0]}};
            end
            memop_pkg::OP_SH: begin
                wstrb = byte_off[1] ? 4'b1100 : 4'b0011;
                wdata = {2{rt[15:0]}};
            end
            memop_pkg::OP_SWL: begin
                wstrb = 4'b1111 >> (2'd3 - byte_off);    // bytes 0..a
                wdata = rt >> sh_dn;
            end
            memop_pkg::OP_SWR: begin
                wstrb = 4'b1111 << byte_off;    // bytes a..3
                wdata = rt << sh_up;
            end
            memop_pkg::OP_SW, memop_pkg::OP_SC: begin
                wstrb = 4'b1111;
            end
            default: ;    // loads write nothing
        endcase
    end

    // byte select for the load return path
    always_comb begin
        load_ctl.offset   = byte_off;
        load_ctl.sign_ext = (op == memop_pkg::OP_LB) || (op == memop_pkg::OP_LH);
        case (op)
            memop_pkg::OP_LB, memop_pkg::OP_LBU, memop_pkg::OP_SB:
                load_ctl.size = memop_pkg::LD_BYTE;
            memop_pkg::OP_LH, memop_pkg::OP_LHU, memop_pkg::OP_SH:
                load_ctl.size = memop_pkg::LD_HALF;
            memop_pkg::OP_LWL, memop_pkg::OP_SWL:
                load_ctl.size = memop_pkg::LD_LEFT;
            memop_pkg::OP_LWR, memop_pkg::OP_SWR:
                load_ctl.size = memop_pkg::LD_RIGHT;
            default:
                load_ctl.size = memop_pkg::LD_WORD;    // lw ll sw sc
        endcase
    end

endmodule

// File: mem_access_reg.sv
`timescale 1ns/1ps

module mem_access_reg (
    input  logic                 clk,
    input  logic                 rst_n,
    input  memop_pkg::mem_req_t  req,
    input  mmu_pkg::xlate_t      xlate,
    input  memop_pkg::exc_t      exc_now,
    input  logic                 sc_ok,
    input  logic [3:0]           wstrb,
    input  logic [31:0]          wdata,
    input  memop_pkg::load_ctl_t load_ctl,
    output memop_pkg::mem_access_t access,
    output memop_pkg::exc_t      exc,
    output logic                 sc_result
);

    logic                  is_sc;
    logic                  issue;
    logic                  cached_q;
    logic                  uncached_q;
    logic                  exc_q;
    memop_pkg::mem_access_t acc_d;
    memop_pkg::mem_access_t acc_q;
    memop_pkg::exc_t       exc_d;

    assign is_sc = (req.op == memop_pkg::OP_SC);
    // failed sc drops out here
    assign issue = req.valid && !exc_now.exc && (!is_sc || sc_ok);

    always_comb begin
        acc_d.cached_valid   = 1'b0;    // carried by cached_q
        acc_d.uncached_valid = 1'b0;
        acc_d.store    = memop_pkg::op_is_store(req.op);
        acc_d.paddr    = xlate.paddr;
        acc_d.wstrb    = wstrb;
        acc_d.wdata    = wdata;
        acc_d.load_ctl = load_ctl;
        exc_d = exc_now;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cached_q   <= 1'b0;
            uncached_q <= 1'b0;
            exc_q      <= 1'b0;
            sc_result  <= 1'b0;
        end else begin
            cached_q   <= issue && xlate.cached;
            uncached_q <= issue && !xlate.cached;
            exc_q      <= exc_now.exc;
            sc_result  <= issue && is_sc;
        end
    end

    always_ff @(posedge clk) begin
        acc_q        <= acc_d;
        exc.refill   <= exc_d.refill;
        exc.code     <= exc_d.code;
        exc.badvaddr <= exc_d.badvaddr;
    end

    always_comb begin
        access = acc_q;
        access.cached_valid   = cached_q;
        access.uncached_valid = uncached_q;
        exc.exc = exc_q;
    end

    one_path_only: assert property (
        @(posedge clk) disable iff (!rst_n) !(access.cached_valid && access.uncached_valid)
    ) else $error("cached and uncached valid together");

endmodule

// File: mem1_stage.sv
`timescale 1ns/1ps

module mem1_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  memop_pkg::mem_req_t    req,
    input  mmu_pkg::tlb_resp_t     tlb,
    input  mmu_pkg::cache_attr_t   k0_attr,
    output memop_pkg::mem_access_t access,
    output memop_pkg::exc_t        exc,
    output logic                   sc_result
);

    mmu_pkg::xlate_t      xlate;
    memop_pkg::exc_t      exc_now;
    logic                 sc_ok;
    logic [3:0]           wstrb;
    logic [31:0]          wdata;
    memop_pkg::load_ctl_t load_ctl;

    addr_translate u_xlate (
        .vaddr   (req.vaddr),
        .tlb     (tlb),
        .k0_attr (k0_attr),
        .xlate   (xlate)
    );

    exc_detect u_exc (
        .req     (req),
        .tlb     (tlb),
        .mapped  (xlate.mapped),
        .exc_now (exc_now)
    );

    ll_sc_monitor u_llsc (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .exc_flag (exc_now.exc),
        .sc_ok    (sc_ok)
    );

    // low bits are untranslated so the vaddr offset is the paddr offset
    lane_format u_lanes (
        .op       (req.op),
        .byte_off (xlate.paddr[1:0]),
        .rt       (req.wdata),
        .wstrb    (wstrb),
        .wdata    (wdata),
        .load_ctl (load_ctl)
    );

    mem_access_reg u_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .xlate     (xlate),
        .exc_now   (exc_now),
        .sc_ok     (sc_ok),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .load_ctl  (load_ctl),
        .access    (access),
        .exc       (exc),
        .sc_result (sc_result)
    );

endmodule

// File: mem1_stage_tb.sv
`timescale 1ns/1ps

module mem1_stage_tb;

    localparam int NUM_REQ    = 3000;
    localparam int RST_CYCLES = 16;
    localparam int CLK_NS     = 4;
    // twice the expected run length
    localparam int TIMEOUT_NS = (NUM_REQ + RST_CYCLES + 20) * CLK_NS * 2;

    logic                   clk;
    logic                   rst_n;
    memop_pkg::mem_req_t    req;
    mmu_pkg::tlb_resp_t     tlb;
    mmu_pkg::cache_attr_t   k0_attr;
    memop_pkg::mem_access_t access;
    memop_pkg::exc_t        exc;
    logic                   sc_result;

    // reference model state
    logic                   m_link;
    mmu_pkg::vaddr_t        m_link_addr;
    memop_pkg::mem_access_t exp_acc;
    memop_pkg::exc_t        exp_exc;
    logic                   exp_sc;
    logic                   exp_is_load;
    mmu_pkg::vaddr_t        last_ll_addr;    // for sc address reuse
    memop_pkg::mem_op_e     prev_op;

    mem1_stage uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .tlb       (tlb),
        .k0_attr   (k0_attr),
        .access    (access),
        .exc       (exc),
        .sc_result (sc_result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    function automatic logic is_store_op(memop_pkg::mem_op_e op);
        case (op)
            memop_pkg::OP_SB, memop_pkg::OP_SH, memop_pkg::OP_SW,
            memop_pkg::OP_SWL, memop_pkg::OP_SWR, memop_pkg::OP_SC: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // expected result of one request, then advance the model reservation
    task automatic predict(input memop_pkg::mem_req_t r, input mmu_pkg::tlb_resp_t t,
                           input mmu_pkg::cache_attr_t k0);
        logic [2:0] seg;
        logic       mapped;
        logic       cached;
        logic       store;
        logic       misalign;
        logic       issue;
        int         a;
        seg    = r.vaddr[31:29];
        mapped = (seg != mmu_pkg::SEG_KSEG0) && (seg != mmu_pkg::SEG_KSEG1);
        a      = r.vaddr[1:0];
        store  = is_store_op(r.op);

        exp_acc = '0;
        if (mapped)
            exp_acc.paddr = {t.pfn, r.vaddr[11:0]};
        else
            exp_acc.paddr = {3'b000, r.vaddr[28:0]};
        if (seg == mmu_pkg::SEG_KSEG0)
            cached = (k0 == mmu_pkg::ATTR_CACHED);
        else if (seg == mmu_pkg::SEG_KSEG1)
            cached = 1'b0;
        else
            cached = (t.attr == mmu_pkg::ATTR_CACHED);

        case (r.op)
            memop_pkg::OP_SW, memop_pkg::OP_SC, memop_pkg::OP_LW, memop_pkg::OP_LL:
                misalign = (a != 0);
            memop_pkg::OP_SH, memop_pkg::OP_LH, memop_pkg::OP_LHU:
                misalign = r.vaddr[0];
            default:
                misalign = 1'b0;
        endcase

        exp_exc = '0;
        if (r.valid) begin
            if (misalign) begin
                exp_exc.exc  = 1'b1;
                exp_exc.code = store ? memop_pkg::EXC_ADES : memop_pkg::EXC_ADEL;
            end else if (mapped && (!t.found || !t.valid)) begin
                exp_exc.exc    = 1'b1;
                exp_exc.refill = !t.found;
                exp_exc.code   = store ? memop_pkg::EXC_TLBS : memop_pkg::EXC_TLBL;
            end else if (mapped && store && !t.dirty) begin
                exp_exc.exc  = 1'b1;
                exp_exc.code = memop_pkg::EXC_MOD;
            end
            if (exp_exc.exc)
                exp_exc.badvaddr = r.vaddr;
        end

        issue = r.valid && !exp_exc.exc;
        if (r.op == memop_pkg::OP_SC)
            issue = issue && m_link && (m_link_addr == r.vaddr);
        exp_acc.cached_valid   = issue && cached;
        exp_acc.uncached_valid = issue && !cached;
        exp_acc.store          = store;
        exp_sc                 = issue && (r.op == memop_pkg::OP_SC);
        exp_is_load            = !store;

        // byte lanes, little endian
        for (int i = 0; i < 4; i++) begin
            case (r.op)
                memop_pkg::OP_SB: if (i == a) begin
                    exp_acc.wstrb[i]       = 1'b1;
                    exp_acc.wdata[8*i +: 8] = r.wdata[7:0];
                end
                memop_pkg::OP_SH: if (i[1] == a[1]) begin
                    exp_acc.wstrb[i]       = 1'b1;
                    exp_acc.wdata[8*i +: 8] = r.wdata[8*(i%2) +: 8];
                end
                memop_pkg::OP_SWL: if (i <= a) begin
                    exp_acc.wstrb[i]       = 1'b1;
                    exp_acc.wdata[8*i +: 8] = r.wdata[8*(3-a+i) +: 8];
                end
                memop_pkg::OP_SWR: if (i >= a) begin
                    exp_acc.wstrb[i]       = 1'b1;
                    exp_acc.wdata[8*i +: 8] = r.wdata[8*(i-a) +: 8];
                end
                memop_pkg::OP_SW, memop_pkg::OP_SC: begin
                    exp_acc.wstrb[i]       = 1'b1;
                    exp_acc.wdata[8*i +: 8] = r.wdata[8*i +: 8];
                end
                default: ;
            endcase
        end

        case (r.op)
            memop_pkg::OP_LB, memop_pkg::OP_LBU: exp_acc.load_ctl.size = memop_pkg::LD_BYTE;
            memop_pkg::OP_LH, memop_pkg::OP_LHU: exp_acc.load_ctl.size = memop_pkg::LD_HALF;
            memop_pkg::OP_LWL:                   exp_acc.load_ctl.size = memop_pkg::LD_LEFT;
            memop_pkg::OP_LWR:                   exp_acc.load_ctl.size = memop_pkg::LD_RIGHT;
            default:                             exp_acc.load_ctl.size = memop_pkg::LD_WORD;
        endcase
        exp_acc.load_ctl.sign_ext = (r.op == memop_pkg::OP_LB) || (r.op == memop_pkg::OP_LH);
        exp_acc.load_ctl.offset   = r.vaddr[1:0];

        if (r.valid && exp_exc.exc) begin
            m_link = 1'b0;
        end else if (r.valid && r.op == memop_pkg::OP_LL) begin
            m_link      = 1'b1;
            m_link_addr = r.vaddr;
        end
    endtask

    task automatic check_outputs();
        check("access.cached_valid", access.cached_valid, exp_acc.cached_valid);
        check("access.uncached_valid", access.uncached_valid, exp_acc.uncached_valid);
        check("sc_result", sc_result, exp_sc);
        check("exc.exc", exc.exc, exp_exc.exc);
        check("exc.refill", exc.refill, exp_exc.refill);
        check("exc.code", exc.code, exp_exc.code);
        check("exc.badvaddr", exc.badvaddr, exp_exc.badvaddr);
        if (exp_acc.cached_valid || exp_acc.uncached_valid) begin
            check("access.store", access.store, exp_acc.store);
            check("access.paddr", access.paddr, exp_acc.paddr);
            if (!exp_is_load) begin
                check("access.wstrb", access.wstrb, exp_acc.wstrb);
                for (int i = 0; i < 4; i++)
                    if (exp_acc.wstrb[i])
                        check($sformatf("access.wdata byte %0d", i),
                              access.wdata[8*i +: 8], exp_acc.wdata[8*i +: 8]);
            end else begin
                check("access.load_ctl.size", access.load_ctl.size, exp_acc.load_ctl.size);
                check("access.load_ctl.sign_ext", access.load_ctl.sign_ext,
                      exp_acc.load_ctl.sign_ext);
                check("access.load_ctl.offset", access.load_ctl.offset,
                      exp_acc.load_ctl.offset);
            end
        end
    endtask

    task automatic drive_random_request();
        memop_pkg::mem_req_t r;
        mmu_pkg::tlb_resp_t  t;
        logic [31:0]         rnd;
        int unsigned         opn;
        opn = $urandom % 14;
        if (prev_op == memop_pkg::OP_LL && $urandom % 3 == 0)
            opn = memop_pkg::OP_SC;    // push sc right after ll
        r.op    = memop_pkg::mem_op_e'(opn);
        r.valid = ($urandom % 10 != 0);
        r.vaddr = $urandom;
        r.wdata = $urandom;
        case (r.op)
            memop_pkg::OP_SW, memop_pkg::OP_SC, memop_pkg::OP_LW, memop_pkg::OP_LL:
                if ($urandom % 4 != 0) r.vaddr[1:0] = 2'b00;
            memop_pkg::OP_SH, memop_pkg::OP_LH, memop_pkg::OP_LHU:
                if ($urandom % 4 != 0) r.vaddr[0] = 1'b0;
            default: ;
        endcase
        if (r.op == memop_pkg::OP_SC && $urandom % 4 != 0)
            r.vaddr = last_ll_addr;
        if (r.op == memop_pkg::OP_LL)
            last_ll_addr = r.vaddr;

        rnd     = $urandom;
        t.found = ($urandom % 8 != 0);
        t.valid = ($urandom % 8 != 0);
        t.dirty = ($urandom % 4 != 0);
        t.attr  = rnd[2:0];
        t.pfn   = rnd[31:12];
        rnd     = $urandom;

        req     = r;
        tlb     = t;
        k0_attr = rnd[2:0];
        prev_op = r.op;
        predict(r, t, k0_attr);
    endtask

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not complete in time");
        $display("ERRORS FOUND");
        $fatal(1);
    end

    initial begin
        void'($urandom(81));
        rst_n        = 1'b0;
        req          = '0;
        tlb          = '0;
        k0_attr      = '0;
        m_link       = 1'b0;
        m_link_addr  = '0;
        last_ll_addr = '0;
        prev_op      = memop_pkg::OP_SB;
        exp_acc      = '0;
        exp_exc      = '0;
        exp_sc       = 1'b0;
        exp_is_load  = 1'b0;

        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // reset values, nothing sampled yet
        check("access.cached_valid", access.cached_valid, 1'b0);
        check("access.uncached_valid", access.uncached_valid, 1'b0);
        check("exc.exc", exc.exc, 1'b0);
        check("sc_result", sc_result, 1'b0);

        for (int n = 0; n < NUM_REQ; n++) begin
            @(negedge clk);
            check_outputs();    // result of the request driven one cycle ago
            drive_random_request();
        end
        @(negedge clk);
        check_outputs();
        req = '0;

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: mem1_stage.f
mmu_pkg.sv
memop_pkg.sv
addr_translate.sv
exc_detect.sv
ll_sc_monitor.sv
lane_format.sv
mem_access_reg.sv
mem1_stage.sv
mem1_stage_tb.sv
